// File: src/bnn_params.svh
`ifndef BNN_PARAMS_SVH
`define BNN_PARAMS_SVH

// Image and classifier dimensions
`define IMG_BYTES   16
`define NUM_CLASSES 10
`define ADDR_W      7

// Seven-segment patterns, active low, bit order gfedcba
`define SEG_BLANK 7'b1111111
`define SEG_0     7'b1000000
`define SEG_1     7'b1111001
`define SEG_2     7'b0100100
`define SEG_3     7'b0110000
`define SEG_4     7'b0011001
`define SEG_5     7'b0010010
`define SEG_6     7'b0000010
`define SEG_7     7'b1111000
`define SEG_8     7'b0000000
`define SEG_9     7'b0010000

`endif

// File: src/bnn_pkg.sv
`default_nettype none

package bnn_pkg;

  // Command byte sent first in every SPI transfer
  typedef enum logic [7:0] {
    OP_LOAD  = 8'h01,
    OP_RUN   = 8'h02,
    OP_CLEAR = 8'h03
  } opcode_e;

  // Status code seen on the status pins
  typedef enum logic [3:0] {
    ST_IDLE    = 4'd0,
    ST_LOADING = 4'd1,
    ST_LOADED  = 4'd2,
    ST_BUSY    = 4'd3,
    ST_DONE    = 4'd4,
    ST_ERROR   = 4'd5
  } status_e;

  typedef enum logic [2:0] {
    S_OPCODE,
    S_DATA,
    S_WAIT_WR,
    S_RUN,
    S_CLEAR
  } fsm_state_e;

  // Fixed weight byte for class k and image byte j
  function automatic logic [7:0] weight_byte(input int k, input int j);
    logic [7:0] raw;
    raw = 8'(13 * j + 71 * k + 5);
    return raw ^ 8'hA5;
  endfunction

endpackage

`default_nettype wire

// File: src/buf_wr_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "bnn_params.svh"

interface buf_wr_if;
  logic                req;
  logic                ready;
  logic [`ADDR_W-1:0]  addr;
  logic [7:0]          data;

  // Controller side issues writes
  modport ctrl (output req, output addr, output data, input ready);

  // Buffer side accepts them
  modport mem (input req, input addr, input data, output ready);
endinterface

`default_nettype wire

// File: src/spi_rx.sv
`timescale 1ns/1ps
`default_nettype none

module spi_rx (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       sclk,
  input  logic       copi,
  input  logic       cs_n,
  output logic [7:0] rx_data,
  output logic       byte_valid,
  output logic       cs_n_sync
);

  // ====================
  // Pin synchronizers
  // ====================
  // Extra sclk stage holds the previous value for edge detection
  logic [2:0] sclk_q;
  logic [1:0] copi_q;
  logic [1:0] cs_n_q;
  logic       sclk_rise;
  logic       sample;
  logic [2:0] bit_cnt;
  logic [6:0] shift_reg;
  logic [7:0] next_byte;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sclk_q <= '0;
      copi_q <= '0;
      cs_n_q <= 2'b11;
    end else begin
      sclk_q <= {sclk_q[1:0], sclk};
      copi_q <= {copi_q[0], copi};
      cs_n_q <= {cs_n_q[0], cs_n};
    end
  end

  assign cs_n_sync = cs_n_q[1];
  assign sclk_rise = sclk_q[1] & ~sclk_q[2];
  assign sample    = sclk_rise & ~cs_n_sync;
  assign next_byte = {shift_reg, copi_q[1]};

  // ====================
  // Bit counter
  // ====================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      bit_cnt    <= '0;
      byte_valid <= 1'b0;
    end else begin
      byte_valid <= sample && (bit_cnt == 3'd7);
      if (cs_n_sync) begin
        bit_cnt <= '0;
      end else if (sample) begin
        bit_cnt <= bit_cnt + 3'd1;
      end
    end
  end

  // MSB first, so new bits enter at the bottom
  always_ff @(posedge clk) begin
    if (sample) begin
      shift_reg <= next_byte[6:0];
      if (bit_cnt == 3'd7) begin
        rx_data <= next_byte;
      end
    end
  end

endmodule

`default_nettype wire

// File: src/cmd_fsm.sv
`timescale 1ns/1ps
`default_nettype none

`include "bnn_params.svh"

module cmd_fsm (
  input  logic             clk,
  input  logic             rst_n,
  input  logic [7:0]       rx_data,
  input  logic             byte_valid,
  input  logic             cs_n_sync,
  buf_wr_if.ctrl           wr,
  output logic             clear,
  input  logic             full,
  output logic             start,
  input  logic             done,
  output bnn_pkg::status_e status
);
  import bnn_pkg::*;

  localparam logic [`ADDR_W-1:0] last_addr = `ADDR_W'(`IMG_BYTES - 1);

  fsm_state_e         state;
  logic [`ADDR_W-1:0] wr_cnt;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state  <= S_OPCODE;
      status <= ST_IDLE;
      wr.req <= 1'b0;
      wr_cnt <= '0;
      clear  <= 1'b0;
      start  <= 1'b0;
    end else begin
      start <= 1'b0;
      clear <= 1'b0;
      case (state)
        S_OPCODE: begin
          if (byte_valid) begin
            case (rx_data)
              OP_LOAD: begin
                state  <= S_DATA;
                wr_cnt <= '0;
                status <= ST_LOADING;
              end
              OP_RUN: begin
                // Classify only a complete image
                if (full) begin
                  start  <= 1'b1;
                  state  <= S_RUN;
                  status <= ST_BUSY;
                end else begin
                  status <= ST_ERROR;
                end
              end
              OP_CLEAR: begin
                clear <= 1'b1;
                state <= S_CLEAR;
              end
              default: status <= ST_ERROR;
            endcase
          end
        end
        S_DATA: begin
          if (byte_valid) begin
            wr.req <= 1'b1;
            state  <= S_WAIT_WR;
          end else if (cs_n_sync) begin
            state <= S_OPCODE;   // short LOAD, status stays ST_LOADING
          end
        end
        S_WAIT_WR: begin
          if (wr.req && wr.ready) begin
            wr.req <= 1'b0;
            wr_cnt <= wr_cnt + 1'b1;
            if (wr_cnt == last_addr) begin
              status <= ST_LOADED;
              state  <= S_OPCODE;
            end else begin
              state <= S_DATA;
            end
          end
        end
        S_RUN: begin
          if (done) begin
            status <= ST_DONE;
            state  <= S_OPCODE;
          end
        end
        S_CLEAR: begin
          // Buffer sees clear one cycle late, so skip the pulse cycle
          if (!clear && wr.ready) begin
            status <= ST_IDLE;
            state  <= S_OPCODE;
          end
        end
        default: state <= S_OPCODE;
      endcase
    end
  end

  // Write payload, held until the handshake
  always_ff @(posedge clk) begin
    if (state == S_DATA && byte_valid) begin
      wr.addr <= wr_cnt;
      wr.data <= rx_data;
    end
  end

endmodule

`default_nettype wire

// File: src/image_buffer.sv
`timescale 1ns/1ps
`default_nettype none

`include "bnn_params.svh"

module image_buffer (
  input  logic               clk,
  input  logic               rst_n,
  buf_wr_if.mem              wr,
  input  logic               clear,
  output logic               full,
  input  logic [`ADDR_W-1:0] rd_addr,
  output logic [7:0]         rd_data
);

  localparam int mem_depth = 1 << `ADDR_W;
  localparam logic [`ADDR_W-1:0] last_addr = `ADDR_W'(`IMG_BYTES - 1);

  logic [7:0]         mem [mem_depth];
  logic [`ADDR_W-1:0] fill_cnt;
  logic [`ADDR_W-1:0] clr_cnt;
  logic               clearing;
  logic               wr_fire;

  assign wr.ready = ~clearing;
  assign wr_fire  = wr.req & wr.ready;
  assign rd_data  = mem[rd_addr];

  // Fill count and clear walk
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      clearing <= 1'b0;
      clr_cnt  <= '0;
      fill_cnt <= '0;
      full     <= 1'b0;
    end else if (clear) begin
      clearing <= 1'b1;
      clr_cnt  <= '0;
      fill_cnt <= '0;
      full     <= 1'b0;
    end else if (clearing) begin
      clr_cnt <= clr_cnt + 1'b1;
      if (clr_cnt == last_addr) begin
        clearing <= 1'b0;
      end
    end else if (wr_fire && !full) begin
      fill_cnt <= fill_cnt + 1'b1;
      if (fill_cnt == last_addr) begin
        full <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (clearing) begin
      mem[clr_cnt] <= 8'h00;
    end else if (wr_fire) begin
      mem[wr.addr] <= wr.data;
    end
  end

endmodule

`default_nettype wire

// File: src/bnn_classifier.sv
`timescale 1ns/1ps
`default_nettype none

`include "bnn_params.svh"

module bnn_classifier (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               start,
  input  logic               clear,
  output logic [`ADDR_W-1:0] rd_addr,
  input  logic [7:0]         rd_data,
  output logic               done,
  output logic [6:0]         seg
);
  import bnn_pkg::*;

  localparam int score_w = $clog2(`IMG_BYTES * 8 + 1);
  localparam logic [`ADDR_W-1:0] last_addr = `ADDR_W'(`IMG_BYTES - 1);

  logic [`ADDR_W-1:0] byte_cnt;
  logic               busy;
  logic               stream;
  logic               argmax_go;
  logic               result_go;
  logic [score_w-1:0] score [`NUM_CLASSES];
  logic [3:0]         match [`NUM_CLASSES];
  logic [score_w-1:0] best_val;
  logic [3:0]         best_idx;
  logic [3:0]         best_class;

  function automatic logic [6:0] seg_pattern(input logic [3:0] digit);
    case (digit)
      4'd0:    return `SEG_0;
      4'd1:    return `SEG_1;
      4'd2:    return `SEG_2;
      4'd3:    return `SEG_3;
      4'd4:    return `SEG_4;
      4'd5:    return `SEG_5;
      4'd6:    return `SEG_6;
      4'd7:    return `SEG_7;
      4'd8:    return `SEG_8;
      4'd9:    return `SEG_9;
      default: return `SEG_BLANK;
    endcase
  endfunction

  // Byte 0 is read in the start cycle itself
  assign rd_addr = byte_cnt;
  assign stream  = start | busy;

  // ====================
  // Scoring
  // ====================
  always_comb begin
    for (int k = 0; k < `NUM_CLASSES; k++) begin
      match[k] = 4'($countones(~(rd_data ^ weight_byte(k, int'(byte_cnt)))));
    end
  end

  // Strict compare keeps the lowest class on ties
  always_comb begin
    best_idx = '0;
    best_val = score[0];
    for (int k = 1; k < `NUM_CLASSES; k++) begin
      if (score[k] > best_val) begin
        best_val = score[k];
        best_idx = 4'(k);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (stream) begin
      for (int k = 0; k < `NUM_CLASSES; k++) begin
        score[k] <= (start ? '0 : score[k]) + score_w'(match[k]);
      end
    end
    if (argmax_go) begin
      best_class <= best_idx;
    end
  end

  // ====================
  // Sequencing
  // ====================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      byte_cnt  <= '0;
      busy      <= 1'b0;
      argmax_go <= 1'b0;
      result_go <= 1'b0;
      done      <= 1'b0;
      seg       <= `SEG_BLANK;
    end else begin
      argmax_go <= 1'b0;
      result_go <= argmax_go;
      done      <= result_go;
      if (stream) begin
        if (byte_cnt == last_addr) begin
          byte_cnt  <= '0;
          busy      <= 1'b0;
          argmax_go <= 1'b1;
        end else begin
          byte_cnt <= byte_cnt + 1'b1;
          busy     <= 1'b1;
        end
      end
      if (clear) begin
        seg <= `SEG_BLANK;
      end else if (result_go) begin
        seg <= seg_pattern(best_class);
      end
    end
  end

endmodule

`default_nettype wire

// File: src/bnn_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "bnn_params.svh"

module bnn_top (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       sclk,
  input  logic       copi,
  input  logic       cs_n,
  output logic [3:0] status,
  output logic [6:0] seg
);

  logic [7:0]         rx_data;
  logic               byte_valid;
  logic               cs_n_sync;
  logic               clear;
  logic               full;
  logic               start;
  logic               done;
  logic [`ADDR_W-1:0] rd_addr;
  logic [7:0]         rd_data;

  // Buffer write path
  buf_wr_if wr_bus ();

  spi_rx u_spi_rx (
    .clk        (clk),
    .rst_n      (rst_n),
    .sclk       (sclk),
    .copi       (copi),
    .cs_n       (cs_n),
    .rx_data    (rx_data),
    .byte_valid (byte_valid),
    .cs_n_sync  (cs_n_sync)
  );

  cmd_fsm u_cmd_fsm (
    .clk        (clk),
    .rst_n      (rst_n),
    .rx_data    (rx_data),
    .byte_valid (byte_valid),
    .cs_n_sync  (cs_n_sync),
    .wr         (wr_bus.ctrl),
    .clear      (clear),
    .full       (full),
    .start      (start),
    .done       (done),
    .status     (status)
  );

  image_buffer u_image_buffer (
    .clk     (clk),
    .rst_n   (rst_n),
    .wr      (wr_bus.mem),
    .clear   (clear),
    .full    (full),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

  bnn_classifier u_bnn_classifier (
    .clk     (clk),
    .rst_n   (rst_n),
    .start   (start),
    .clear   (clear),
    .rd_addr (rd_addr),
    .rd_data (rd_data),
    .done    (done),
    .seg     (seg)
  );

endmodule

`default_nettype wire

// File: sim/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
  parameter int half_ns = 4
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever #(half_ns) clk = ~clk;
  end

endmodule

`default_nettype wire

// File: sim/bnn_props.sv
`timescale 1ns/1ps
`default_nettype none

`include "bnn_params.svh"

module bnn_props (
  input logic                clk,
  input logic                rst_n,
  input logic                start,
  input logic                full,
  input logic                byte_valid,
  input bnn_pkg::fsm_state_e state,
  input logic                req,
  input logic                ready,
  input logic [`ADDR_W-1:0]  addr,
  input logic [7:0]          data
);
  import bnn_pkg::*;

  int fail_cnt = 0;

  start_needs_full: assert property (@(posedge clk) disable iff (!rst_n) start |-> full)
    else begin
      fail_cnt++;
      $error("start issued while the image buffer is not full");
    end

  // Write request held steady until the buffer takes it
  req_held: assert property (@(posedge clk) disable iff (!rst_n)
    req && !ready |=> req && $stable(addr) && $stable(data))
    else begin
      fail_cnt++;
      $error("write request dropped or changed before ready");
    end

  no_byte_in_wait: assert property (@(posedge clk) disable iff (!rst_n)
    state == S_WAIT_WR |-> !byte_valid)
    else begin
      fail_cnt++;
      $error("byte arrived while a buffer write was pending");
    end

endmodule

bind cmd_fsm bnn_props props (
  .clk        (clk),
  .rst_n      (rst_n),
  .start      (start),
  .full       (full),
  .byte_valid (byte_valid),
  .state      (state),
  .req        (wr.req),
  .ready      (wr.ready),
  .addr       (wr.addr),
  .data       (wr.data)
);

`default_nettype wire

// File: sim/bnn_checker.sv
`timescale 1ns/1ps
`default_nettype none

module bnn_checker #(
  parameter int check_wait = 40
) (
  input  logic       clk,
  input  logic       check_req,
  input  logic [7:0] test_no,
  input  logic [3:0] exp_status,
  input  logic [6:0] exp_seg,
  input  logic [3:0] status,
  input  logic [6:0] seg,
  input  logic       report,
  output logic       reported,
  output int         checks_done,
  output int         err_cnt
);

  int pass_cnt;

  // ====================
  // Compare
  // ====================
  initial begin : compare
    logic [7:0] test_id;
    logic [3:0] want_status;
    logic [6:0] want_seg;
    logic       ok;
    checks_done = 0;
    err_cnt     = 0;
    pass_cnt    = 0;
    forever begin
      @(posedge clk);
      if (check_req) begin
        test_id     = test_no;
        want_status = exp_status;
        want_seg    = exp_seg;
        ok          = 1'b1;
        repeat (check_wait) @(posedge clk);
        // Sample mid-cycle, away from the DUT's clock edge
        @(negedge clk);
        if (status !== want_status) begin
          $display("error status expected 0x%h got 0x%h", want_status, status);
          ok = 1'b0;
        end
        if (seg !== want_seg) begin
          $display("error seg expected 0x%h got 0x%h", want_seg, seg);
          ok = 1'b0;
        end
        if (ok) begin
          pass_cnt++;
          $display("test %0d, check %0d passed", test_id, checks_done + 1);
        end else begin
          err_cnt++;
          $display("test %0d, check %0d failed", test_id, checks_done + 1);
        end
        checks_done++;
      end
    end
  end

  // Closing counts
  initial begin
    reported = 1'b0;
    wait (report);
    @(negedge clk);
    $display("%0d checks, %0d passed, %0d failed", checks_done, pass_cnt, err_cnt);
    reported = 1'b1;
  end

endmodule

`default_nettype wire

// File: sim/bnn_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "bnn_params.svh"

module bnn_tb;
  import bnn_pkg::*;

  localparam int half_sclk   = 8;
  localparam int n_checks    = 11;
  // Seven image loads plus eight runs, six clears and one bad opcode
  localparam int total_bytes = 7 * (`IMG_BYTES + 1) + 15;
  localparam int cycle_limit = total_bytes * 128 + 4000;

  logic        clk;
  logic        rst_n;
  logic        sclk;
  logic        copi;
  logic        cs_n;
  logic [3:0]  status;
  logic [6:0]  seg;
  logic        check_req;
  logic [7:0]  test_no;
  logic [3:0]  exp_status;
  logic [6:0]  exp_seg;
  logic        report;
  logic        reported;
  int          checks_done;
  int          err_cnt;
  int          cycle_cnt;
  logic [31:0] lfsr;
  logic [7:0]  image [`IMG_BYTES];

  tb_clock clk_gen (
    .clk (clk)
  );

  bnn_top dut (
    .clk    (clk),
    .rst_n  (rst_n),
    .sclk   (sclk),
    .copi   (copi),
    .cs_n   (cs_n),
    .status (status),
    .seg    (seg)
  );

  bnn_checker #(
    .check_wait (`IMG_BYTES + 24)
  ) chk (
    .clk         (clk),
    .check_req   (check_req),
    .test_no     (test_no),
    .exp_status  (exp_status),
    .exp_seg     (exp_seg),
    .status      (status),
    .seg         (seg),
    .report      (report),
    .reported    (reported),
    .checks_done (checks_done),
    .err_cnt     (err_cnt)
  );

  // ====================
  // Reference model
  // ====================
  // Galois LFSR with taps at 32, 22, 2 and 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  // Highest count of matching bits wins and ties go to the lowest class
  function automatic int ref_class(input logic [7:0] img [`IMG_BYTES]);
    int         best;
    int         best_score;
    int         score;
    logic [7:0] w;
    best       = 0;
    best_score = -1;
    for (int k = 0; k < `NUM_CLASSES; k++) begin
      score = 0;
      for (int j = 0; j < `IMG_BYTES; j++) begin
        w = 8'((13 * j + 71 * k + 5) % 256) ^ 8'hA5;
        for (int b = 0; b < 8; b++) begin
          if (img[j][b] == w[b]) begin
            score++;
          end
        end
      end
      if (score > best_score) begin
        best_score = score;
        best       = k;
      end
    end
    return best;
  endfunction

  function automatic logic [6:0] digit_seg(input int d);
    case (d)
      0:       return `SEG_0;
      1:       return `SEG_1;
      2:       return `SEG_2;
      3:       return `SEG_3;
      4:       return `SEG_4;
      5:       return `SEG_5;
      6:       return `SEG_6;
      7:       return `SEG_7;
      8:       return `SEG_8;
      9:       return `SEG_9;
      default: return `SEG_BLANK;
    endcase
  endfunction

  // ====================
  // SPI driver
  // ====================
  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk);
    #1;
  endtask

  // Mode 0 with MSB first
  task automatic spi_byte(input logic [7:0] b);
    for (int i = 7; i >= 0; i--) begin
      copi = b[i];
      wait_cycles(half_sclk);
      sclk = 1'b1;
      wait_cycles(half_sclk);
      sclk = 1'b0;
    end
  endtask

  task automatic begin_xfer();
    wait_cycles(half_sclk);
    cs_n = 1'b0;
  endtask

  task automatic end_xfer();
    wait_cycles(half_sclk);
    cs_n = 1'b1;
    wait_cycles(half_sclk);
  endtask

  task automatic send_cmd(input logic [7:0] op);
    begin_xfer();
    spi_byte(op);
    end_xfer();
  endtask

  task automatic load_image();
    begin_xfer();
    spi_byte(OP_LOAD);
    for (int j = 0; j < `IMG_BYTES; j++) begin
      spi_byte(image[j]);
    end
    end_xfer();
  endtask

  // One LFSR step per image bit
  task automatic fill_image();
    logic [7:0] b;
    b = '0;
    for (int j = 0; j < `IMG_BYTES; j++) begin
      for (int i = 0; i < 8; i++) begin
        lfsr = lfsr_next(lfsr);
        b    = {b[6:0], lfsr[0]};
      end
      image[j] = b;
    end
  endtask

  task automatic expect_check(input int test, input logic [3:0] st, input logic [6:0] sg);
    int target;
    target     = checks_done + 1;
    test_no    = 8'(test);
    exp_status = st;
    exp_seg    = sg;
    check_req  = 1'b1;
    wait_cycles(1);
    check_req = 1'b0;
    while (checks_done < target) begin
      wait_cycles(1);
    end
  endtask

  // ====================
  // Test sequence
  // ====================
  initial begin
    rst_n      = 1'b0;
    sclk       = 1'b0;
    copi       = 1'b0;
    cs_n       = 1'b1;
    check_req  = 1'b0;
    test_no    = '0;
    exp_status = '0;
    exp_seg    = '0;
    report     = 1'b0;
    lfsr       = 32'hef566e1f;
    wait_cycles(4);
    rst_n = 1'b1;

    expect_check(1, ST_IDLE, `SEG_BLANK);

    fill_image();
    load_image();
    expect_check(2, ST_LOADED, `SEG_BLANK);
    send_cmd(OP_RUN);
    expect_check(2, ST_DONE, digit_seg(ref_class(image)));

    // Buffer is empty so the run is refused
    send_cmd(OP_CLEAR);
    send_cmd(OP_RUN);
    expect_check(3, ST_ERROR, `SEG_BLANK);

    send_cmd(8'h5A);
    expect_check(4, ST_ERROR, `SEG_BLANK);
    fill_image();
    load_image();
    send_cmd(OP_RUN);
    expect_check(4, ST_DONE, digit_seg(ref_class(image)));

    repeat (5) begin
      fill_image();
      send_cmd(OP_CLEAR);
      load_image();
      send_cmd(OP_RUN);
      expect_check(5, ST_DONE, digit_seg(ref_class(image)));
    end

    report = 1'b1;
    while (!reported) begin
      wait_cycles(1);
    end
    if (checks_done != n_checks) begin
      $display("Only %0d of %0d checks completed", checks_done, n_checks);
    end
    if (dut.u_cmd_fsm.props.fail_cnt != 0) begin
      $display("%0d assertion failures in the command FSM", dut.u_cmd_fsm.props.fail_cnt);
    end
    if (err_cnt == 0 && checks_done == n_checks && dut.u_cmd_fsm.props.fail_cnt == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  // Watchdog
  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < cycle_limit) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("Run timed out after %0d cycles", cycle_cnt);
    $display("Finished with errors");
    $finish;
  end

endmodule

`default_nettype wire

// File: bnn.f
+incdir+src
src/bnn_pkg.sv
src/buf_wr_if.sv
src/spi_rx.sv
src/cmd_fsm.sv
src/image_buffer.sv
src/bnn_classifier.sv
src/bnn_top.sv
sim/tb_clock.sv
sim/bnn_props.sv
sim/bnn_checker.sv
sim/bnn_tb.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := bnn_tb
FILELIST  := bnn.f
LOG       := sim.log
FAIL_MSG  := Finished with errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
